//--- hw/nandc_cfg.svh
`ifndef NANDC_CFG_SVH
`define NANDC_CFG_SVH

// flash timing, counted in tRC half periods of wb_clk
`define NANDC_TRC        2
`define NANDC_TWB        5
`define NANDC_TWHR       3

// address cycles for one full column plus row address
`define NANDC_ADDR_CYC   4

// geometry in address bits, columns include the spare area bit
`define NANDC_FCOLUMNS   12
`define NANDC_FPAGES     6

// flash window, first block mapped and block count
`define NANDC_FLASH_BASE 32'h0000_0000
`define NANDC_FLASH_S    4
`define NANDC_FLASH_N    16

// register map
`define NANDC_REG_BASE   32'h1000_0000
`define NANDC_ERASE_OFF  32'h0000_0000
`define NANDC_STATUS_OFF 32'h0000_0004

`endif

//--- hw/nand_flash_pkg.sv
package nand_flash_pkg;

   // one byte on the flash io bus
   typedef logic [7:0] flash_byte_t;

   // one bus step of the flash interface
   typedef enum logic [2:0] {
      STEP_CMD,
      // ALE latch of one address byte
      STEP_ADDR,
      // tWB, then poll ready/busy
      STEP_WAIT_RB,
      // gap between status command and first RE
      STEP_WAIT_WHR,
      // one RE cycle with a sampled byte
      STEP_READ
   } step_kind_e;

   // command opcodes of the part
   localparam flash_byte_t FCMD_READ_0    = 8'h00;
   localparam flash_byte_t FCMD_READ_1    = 8'h30;
   localparam flash_byte_t FCMD_ERASE_0   = 8'h60;
   localparam flash_byte_t FCMD_ERASE_1   = 8'hd0;
   localparam flash_byte_t FCMD_READ_STAT = 8'h70;

endpackage

//--- hw/nand_host_pkg.sv
package nand_host_pkg;

   // operations the bus slave can hand to the sequencer
   typedef enum logic [1:0] {
      OP_READ,
      OP_ERASE,
      OP_STATUS
   } op_kind_e;

   // wishbone data word
   typedef logic [31:0] host_word_t;

   // flash page address and byte column
   typedef logic [15:0] row_t;
   typedef logic [11:0] col_t;

endpackage

//--- hw/nand_wb_slave.sv
`include "nandc_cfg.svh"

module nand_wb_slave
   import nand_host_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  host_word_t wbs_adr_i,
   input  host_word_t wbs_dat_i,
   input  logic       wbs_cyc_i,
   input  logic       wbs_stb_i,
   input  logic       wbs_we_i,
   output host_word_t wbs_dat_o,
   output logic       wbs_ack_o,
   output logic       op_valid_o,
   input  logic       op_ready_i,
   output op_kind_e   op_kind_o,
   output row_t       op_row_o,
   output col_t       op_col_o,
   input  logic       done_valid_i,
   input  host_word_t done_data_i
);

   localparam host_word_t ERASE_ADDR  = `NANDC_REG_BASE + `NANDC_ERASE_OFF;
   localparam host_word_t STATUS_ADDR = `NANDC_REG_BASE + `NANDC_STATUS_OFF;
   localparam host_word_t FLASH_END   =
      `NANDC_FLASH_BASE + (`NANDC_FLASH_N << (`NANDC_FPAGES + `NANDC_FCOLUMNS));
   localparam host_word_t BLK_FIRST   = `NANDC_FLASH_S;
   localparam host_word_t BLK_END     = `NANDC_FLASH_S + `NANDC_FLASH_N;
   localparam row_t       ROW_BASE    = row_t'(`NANDC_FLASH_S << `NANDC_FPAGES);

   typedef enum logic [2:0] {
      S_IDLE,
      S_REJECT,
      S_BUSY,
      S_ACK,
      S_GAP
   } state_e;

   state_e     state;
   host_word_t flash_off;
   logic       req;
   logic       in_window;
   logic       is_read;
   logic       is_erase;
   logic       is_status;

   assign req       = wbs_cyc_i && wbs_stb_i;
   assign flash_off = wbs_adr_i - `NANDC_FLASH_BASE;
   assign in_window = (wbs_adr_i >= `NANDC_FLASH_BASE) && (wbs_adr_i < FLASH_END);
   assign is_read   = !wbs_we_i && in_window;
   assign is_status = !wbs_we_i && (wbs_adr_i == STATUS_ADDR);
   // write data is a block number, only mapped blocks may be erased
   assign is_erase  = wbs_we_i && (wbs_adr_i == ERASE_ADDR) &&
                      (wbs_dat_i >= BLK_FIRST) && (wbs_dat_i < BLK_END);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state      <= S_IDLE;
         op_valid_o <= 1'b0;
         wbs_ack_o  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (req) begin
                  if (is_read || is_erase || is_status) begin
                     op_valid_o <= 1'b1;
                     state      <= S_BUSY;
                  end else begin
                     state <= S_REJECT;
                  end
               end
            end
            // no flash activity, answer with zero
            S_REJECT: begin
               wbs_dat_o <= '0;
               wbs_ack_o <= 1'b1;
               state     <= S_ACK;
            end
            S_BUSY: begin
               if (op_ready_i) begin
                  op_valid_o <= 1'b0;
               end
               if (done_valid_i) begin
                  wbs_dat_o <= done_data_i;
                  wbs_ack_o <= 1'b1;
                  state     <= S_ACK;
               end
            end
            S_ACK: begin
               wbs_ack_o <= 1'b0;
               state     <= S_GAP;
            end
            // master may still show the old stb here
            default: state <= S_IDLE;
         endcase
      end
   end

   // operation fields, captured with the request
   always_ff @(posedge wb_clk) begin
      if (state == S_IDLE && req) begin
         op_col_o <= col_t'(flash_off);
         if (is_erase) begin
            op_kind_o <= OP_ERASE;
            op_row_o  <= row_t'(wbs_dat_i << `NANDC_FPAGES);
         end else begin
            op_kind_o <= is_status ? OP_STATUS : OP_READ;
            op_row_o  <= row_t'(flash_off >> `NANDC_FCOLUMNS) + ROW_BASE;
         end
      end
   end

   a_ack_in_cycle: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wbs_ack_o |-> req);

endmodule

//--- hw/nand_op_seq.sv
`include "nandc_cfg.svh"

module nand_op_seq
   import nand_host_pkg::*;
   import nand_flash_pkg::*;
(
   input  logic        wb_clk,
   input  logic        wb_rst,
   input  logic        op_valid_i,
   output logic        op_ready_o,
   input  op_kind_e    op_kind_i,
   input  row_t        op_row_i,
   input  col_t        op_col_i,
   output logic        done_valid_o,
   output host_word_t  done_data_o,
   output logic        step_valid_o,
   input  logic        step_ready_i,
   output step_kind_e  step_kind_o,
   output flash_byte_t step_byte_o,
   input  logic        rd_valid_i,
   input  flash_byte_t rd_byte_i,
   output logic        ce_o
);

   // read: command, address bytes, confirm, busy wait, four data bytes
   localparam logic [3:0] RD_CONFIRM = 4'(`NANDC_ADDR_CYC + 1);
   localparam logic [3:0] RD_WAIT    = 4'(`NANDC_ADDR_CYC + 2);
   localparam logic [3:0] RD_LAST    = 4'(`NANDC_ADDR_CYC + 6);
   // a status read is the tail of the erase sequence
   localparam logic [3:0] STAT_FIRST = 4'd5;

   typedef enum logic [1:0] {
      Q_IDLE,
      Q_ISSUE,
      Q_DRAIN
   } state_e;

   state_e     state;
   op_kind_e   kind_q;
   row_t       row_q;
   col_t       col_q;
   logic [3:0] idx;
   logic       last_step;
   host_word_t addr_word;
   host_word_t rd_word;

   // column goes out first, then row, low byte first
   assign addr_word    = {row_q, 4'h0, col_q};
   assign op_ready_o   = (state == Q_IDLE);
   assign step_valid_o = (state == Q_ISSUE);
   assign ce_o         = (state != Q_IDLE);

   always_comb begin
      step_kind_o = STEP_READ;
      step_byte_o = '0;
      last_step   = 1'b0;
      if (kind_q == OP_READ) begin
         if (idx == 4'd0) begin
            step_kind_o = STEP_CMD;
            step_byte_o = FCMD_READ_0;
         end else if (idx < RD_CONFIRM) begin
            step_kind_o = STEP_ADDR;
            step_byte_o = addr_word[8*(idx - 4'd1) +: 8];
         end else if (idx == RD_CONFIRM) begin
            step_kind_o = STEP_CMD;
            step_byte_o = FCMD_READ_1;
         end else if (idx == RD_WAIT) begin
            step_kind_o = STEP_WAIT_RB;
         end else begin
            last_step = (idx == RD_LAST);
         end
      end else begin
         case (idx)
            4'd0: begin
               step_kind_o = STEP_CMD;
               step_byte_o = FCMD_ERASE_0;
            end
            4'd1: begin
               step_kind_o = STEP_ADDR;
               step_byte_o = row_q[7:0];
            end
            4'd2: begin
               step_kind_o = STEP_ADDR;
               step_byte_o = row_q[15:8];
            end
            4'd3: begin
               step_kind_o = STEP_CMD;
               step_byte_o = FCMD_ERASE_1;
            end
            4'd4: step_kind_o = STEP_WAIT_RB;
            4'd5: begin
               step_kind_o = STEP_CMD;
               step_byte_o = FCMD_READ_STAT;
            end
            4'd6: step_kind_o = STEP_WAIT_WHR;
            default: last_step = 1'b1;
         endcase
      end
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state        <= Q_IDLE;
         idx          <= '0;
         done_valid_o <= 1'b0;
      end else begin
         done_valid_o <= 1'b0;
         case (state)
            Q_IDLE: begin
               if (op_valid_i) begin
                  idx   <= (op_kind_i == OP_STATUS) ? STAT_FIRST : 4'd0;
                  state <= Q_ISSUE;
               end
            end
            Q_ISSUE: begin
               if (step_ready_i) begin
                  idx <= idx + 4'd1;
                  if (last_step) begin
                     state <= Q_DRAIN;
                  end
               end
            end
            // wait for the byte of the final read step
            default: begin
               if (rd_valid_i) begin
                  done_valid_o <= 1'b1;
                  state        <= Q_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge wb_clk) begin
      if (state == Q_IDLE && op_valid_i) begin
         kind_q <= op_kind_i;
         row_q  <= op_row_i;
         col_q  <= op_col_i;
      end
      // first byte ends up in the lowest lane
      if (rd_valid_i) begin
         rd_word <= {rd_byte_i, rd_word[31:8]};
      end
      if (state == Q_DRAIN && rd_valid_i) begin
         if (kind_q == OP_READ) begin
            done_data_o <= {rd_byte_i, rd_word[31:8]};
         end else begin
            // fail bit of the status byte
            done_data_o <= {31'h0, rd_byte_i[0]};
         end
      end
   end

   a_step_held: assert property (@(posedge wb_clk) disable iff (wb_rst)
      step_valid_o && !step_ready_i |=> step_valid_o && $stable(step_kind_o));

endmodule

//--- hw/nand_cycle_gen.sv
`include "nandc_cfg.svh"

module nand_cycle_gen
   import nand_flash_pkg::*;
(
   input  logic        wb_clk,
   input  logic        wb_rst,
   input  logic        step_valid_i,
   output logic        step_ready_o,
   input  step_kind_e  step_kind_i,
   input  flash_byte_t step_byte_i,
   input  logic        ce_i,
   output logic        rd_valid_o,
   output flash_byte_t rd_byte_o,
   input  flash_byte_t io_i,
   output flash_byte_t io_o,
   output flash_byte_t io_t_o,
   output logic        cle_o,
   output logic        ale_o,
   output logic        ce_n_o,
   output logic        we_n_o,
   output logic        re_n_o,
   output logic        wp_n_o,
   input  logic        rb_n_i
);

   localparam flash_byte_t IO_DRIVE = 8'h00;
   localparam flash_byte_t IO_TRI   = 8'hff;

   typedef enum logic [1:0] {
      G_IDLE,
      G_START,
      G_FINISH
   } state_e;

   state_e      state;
   step_kind_e  kind_q;
   flash_byte_t byte_q;
   logic [3:0]  trc_cnt;
   logic        trc;
   logic [3:0]  wait_cnt;
   logic [3:0]  wait_last;
   logic [2:0]  rb_sync;
   logic        is_write;

   assign step_ready_o = (state == G_IDLE);
   // no programming, so write protect stays released
   assign wp_n_o       = 1'b1;
   assign is_write     = (kind_q == STEP_CMD) || (kind_q == STEP_ADDR);
   assign wait_last    = (kind_q == STEP_WAIT_WHR) ? 4'(`NANDC_TWHR - 1)
                                                   : 4'(`NANDC_TWB - 1);

   // free running tRC pulse
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         trc_cnt <= '0;
         trc     <= 1'b0;
      end else if (trc_cnt == 4'(`NANDC_TRC - 1)) begin
         trc_cnt <= '0;
         trc     <= 1'b1;
      end else begin
         trc_cnt <= trc_cnt + 4'd1;
         trc     <= 1'b0;
      end
   end

   // ready/busy comes from the flash clock domain
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         rb_sync <= 3'b111;
      end else begin
         rb_sync <= {rb_sync[1:0], rb_n_i};
      end
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state      <= G_IDLE;
         wait_cnt   <= '0;
         rd_valid_o <= 1'b0;
         cle_o      <= 1'b0;
         ale_o      <= 1'b0;
         ce_n_o     <= 1'b1;
         we_n_o     <= 1'b1;
         re_n_o     <= 1'b1;
         io_t_o     <= IO_TRI;
      end else begin
         rd_valid_o <= 1'b0;
         ce_n_o     <= !ce_i;
         case (state)
            G_IDLE: begin
               if (step_valid_i) begin
                  state <= G_START;
               end
            end
            // first period: strobe asserted, data driven on writes
            G_START: begin
               if (trc) begin
                  cle_o    <= (kind_q == STEP_CMD);
                  ale_o    <= (kind_q == STEP_ADDR);
                  we_n_o   <= !is_write;
                  re_n_o   <= (kind_q != STEP_READ);
                  io_t_o   <= is_write ? IO_DRIVE : IO_TRI;
                  wait_cnt <= '0;
                  state    <= G_FINISH;
               end
            end
            default: begin
               if (trc) begin
                  case (kind_q)
                     // rising WE latches the byte
                     STEP_CMD, STEP_ADDR: begin
                        we_n_o <= 1'b1;
                        state  <= G_IDLE;
                     end
                     STEP_READ: begin
                        re_n_o     <= 1'b1;
                        rd_valid_o <= 1'b1;
                        state      <= G_IDLE;
                     end
                     default: begin
                        if (wait_cnt != wait_last) begin
                           wait_cnt <= wait_cnt + 4'd1;
                        end else if (kind_q == STEP_WAIT_WHR || rb_sync[2]) begin
                           state <= G_IDLE;
                        end
                     end
                  endcase
               end
            end
         endcase
      end
   end

   always_ff @(posedge wb_clk) begin
      if (state == G_IDLE && step_valid_i) begin
         kind_q <= step_kind_i;
         byte_q <= step_byte_i;
      end
      if (state == G_START && trc) begin
         io_o <= byte_q;
      end
      // sample while RE is still low
      if (state == G_FINISH && trc && kind_q == STEP_READ) begin
         rd_byte_o <= io_i;
      end
   end

   a_cle_ale_excl: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(cle_o && ale_o));

endmodule

//--- hw/nandc_top.sv
module nandc_top
   import nand_host_pkg::*;
   import nand_flash_pkg::*;
(
   input  logic        wb_clk,
   input  logic        wb_rst,
   input  host_word_t  wbs_adr_i,
   input  host_word_t  wbs_dat_i,
   input  logic [3:0]  wbs_sel_i,
   input  logic        wbs_cyc_i,
   input  logic        wbs_stb_i,
   input  logic        wbs_we_i,
   output host_word_t  wbs_dat_o,
   output logic        wbs_ack_o,
   input  flash_byte_t io_i,
   output flash_byte_t io_o,
   output flash_byte_t io_t,
   output logic        cle_o,
   output logic        ale_o,
   output logic        ce_n_o,
   output logic        we_n_o,
   output logic        re_n_o,
   output logic        wp_n_o,
   input  logic        rb_n_i
);

   // slave to sequencer
   logic        op_valid;
   logic        op_ready;
   op_kind_e    op_kind;
   row_t        op_row;
   col_t        op_col;
   logic        done_valid;
   host_word_t  done_data;

   // sequencer to cycle generator
   logic        step_valid;
   logic        step_ready;
   step_kind_e  step_kind;
   flash_byte_t step_byte;
   logic        rd_valid;
   flash_byte_t rd_byte;
   logic        ce;

   nand_wb_slave u_slave (
      .wb_clk       (wb_clk),
      .wb_rst       (wb_rst),
      .wbs_adr_i    (wbs_adr_i),
      .wbs_dat_i    (wbs_dat_i),
      .wbs_cyc_i    (wbs_cyc_i),
      .wbs_stb_i    (wbs_stb_i),
      .wbs_we_i     (wbs_we_i),
      .wbs_dat_o    (wbs_dat_o),
      .wbs_ack_o    (wbs_ack_o),
      .op_valid_o   (op_valid),
      .op_ready_i   (op_ready),
      .op_kind_o    (op_kind),
      .op_row_o     (op_row),
      .op_col_o     (op_col),
      .done_valid_i (done_valid),
      .done_data_i  (done_data)
   );

   nand_op_seq u_seq (
      .wb_clk       (wb_clk),
      .wb_rst       (wb_rst),
      .op_valid_i   (op_valid),
      .op_ready_o   (op_ready),
      .op_kind_i    (op_kind),
      .op_row_i     (op_row),
      .op_col_i     (op_col),
      .done_valid_o (done_valid),
      .done_data_o  (done_data),
      .step_valid_o (step_valid),
      .step_ready_i (step_ready),
      .step_kind_o  (step_kind),
      .step_byte_o  (step_byte),
      .rd_valid_i   (rd_valid),
      .rd_byte_i    (rd_byte),
      .ce_o         (ce)
   );

   nand_cycle_gen u_cyc (
      .wb_clk       (wb_clk),
      .wb_rst       (wb_rst),
      .step_valid_i (step_valid),
      .step_ready_o (step_ready),
      .step_kind_i  (step_kind),
      .step_byte_i  (step_byte),
      .ce_i         (ce),
      .rd_valid_o   (rd_valid),
      .rd_byte_o    (rd_byte),
      .io_i         (io_i),
      .io_o         (io_o),
      .io_t_o       (io_t),
      .cle_o        (cle_o),
      .ale_o        (ale_o),
      .ce_n_o       (ce_n_o),
      .we_n_o       (we_n_o),
      .re_n_o       (re_n_o),
      .wp_n_o       (wp_n_o),
      .rb_n_i       (rb_n_i)
   );

endmodule

//--- test/tb_clk_gen.sv
module tb_clk_gen (
   output logic wb_clk,
   output logic wb_rst
);

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   // reset spans two rising edges, released just after the second
   initial begin
      wb_rst = 1'b1;
      repeat (2) @(posedge wb_clk);
      #1 wb_rst = 1'b0;
   end

endmodule

//--- test/nand_flash_model.sv
module nand_flash_model
   import nand_flash_pkg::*;
#(
   parameter int PAGE_BITS   = 6,
   parameter int BUSY_CYCLES = 20
) (
   input  logic        wb_clk,
   input  logic        wb_rst,
   input  logic        cle_i,
   input  logic        ale_i,
   input  logic        ce_n_i,
   input  logic        we_n_i,
   input  logic        re_n_i,
   input  flash_byte_t io_i,
   output flash_byte_t io_o,
   output logic        rb_n_o
);

   flash_byte_t   addr_b [0:3];
   logic [1:0]    addr_cnt;
   logic [15:0]   row;
   logic [11:0]   col;
   logic          stat_mode;
   logic [9:0]    last_erased;
   logic [1023:0] erased;
   logic [4:0]    busy_cnt;
   logic          we_q;
   logic          re_q;

   assign rb_n_o = (busy_cnt == '0);

   // page bytes follow row * 7 + column, erased blocks read all ones
   always_comb begin
      if (stat_mode) begin
         io_o = {2'b11, 5'b00000, (last_erased[2:0] == 3'b111)};
      end else if (erased[row[15:PAGE_BITS]]) begin
         io_o = 8'hff;
      end else begin
         io_o = 8'(row * 7 + col);
      end
   end

   always @(posedge wb_clk) begin
      if (wb_rst) begin
         addr_cnt    <= '0;
         row         <= '0;
         col         <= '0;
         stat_mode   <= 1'b0;
         last_erased <= '0;
         erased      <= '0;
         busy_cnt    <= '0;
         we_q        <= 1'b1;
         re_q        <= 1'b1;
      end else begin
         we_q <= we_n_i;
         re_q <= re_n_i;
         if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 5'd1;
         end
         // latch on the rising edge of WE
         if (!we_q && we_n_i && !ce_n_i) begin
            if (cle_i) begin
               case (io_i)
                  FCMD_READ_0, FCMD_ERASE_0: begin
                     addr_cnt  <= '0;
                     stat_mode <= 1'b0;
                  end
                  FCMD_READ_1: begin
                     col      <= {addr_b[1][3:0], addr_b[0]};
                     row      <= {addr_b[3], addr_b[2]};
                     busy_cnt <= 5'(BUSY_CYCLES);
                  end
                  FCMD_ERASE_1: begin
                     erased[{addr_b[1], addr_b[0]} >> PAGE_BITS] <= 1'b1;
                     last_erased <= 10'({addr_b[1], addr_b[0]} >> PAGE_BITS);
                     busy_cnt    <= 5'(BUSY_CYCLES);
                  end
                  FCMD_READ_STAT: stat_mode <= 1'b1;
                  default: ;
               endcase
            end else if (ale_i) begin
               addr_b[addr_cnt] <= io_i;
               addr_cnt         <= addr_cnt + 2'd1;
            end
         end
         // next column after each RE cycle
         if (!re_q && re_n_i && !stat_mode) begin
            col <= col + 12'd1;
         end
      end
   end

endmodule

//--- test/tb_nandc.sv
`include "nandc_cfg.svh"

module tb_nandc
   import nand_host_pkg::*;
();

   localparam int         WIN_BITS    = `NANDC_FPAGES + `NANDC_FCOLUMNS;
   localparam host_word_t WIN_END     = `NANDC_FLASH_BASE + (`NANDC_FLASH_N << WIN_BITS);
   localparam host_word_t ERASE_ADDR  = `NANDC_REG_BASE + `NANDC_ERASE_OFF;
   localparam host_word_t STATUS_ADDR = `NANDC_REG_BASE + `NANDC_STATUS_OFF;
   localparam int NUM_READS      = 24;
   localparam int NUM_ERASES     = 6;
   localparam int NUM_REJECT     = 6;
   // one status read up front and four accesses per erase round
   localparam int NUM_ACCESS     = 1 + NUM_READS + 4 * NUM_ERASES + NUM_REJECT;
   localparam int TIMEOUT_CYCLES = 400 * NUM_ACCESS;

   logic        wb_clk;
   logic        wb_rst;
   host_word_t  wbs_adr_i;
   host_word_t  wbs_dat_i;
   logic [3:0]  wbs_sel_i;
   logic        wbs_cyc_i;
   logic        wbs_stb_i;
   logic        wbs_we_i;
   host_word_t  wbs_dat_o;
   logic        wbs_ack_o;
   logic [7:0]  io_to_flash;
   logic [7:0]  io_from_flash;
   logic [7:0]  io_t;
   logic        cle;
   logic        ale;
   logic        ce_n;
   logic        we_n;
   logic        re_n;
   logic        wp_n;
   logic        rb_n;

   // reference state of the flash array
   logic [1023:0] ref_erased;
   int            ref_last_blk;
   int            cycle_cnt;
   int            ce_falls;
   logic          ce_n_q;

   tb_clk_gen u_clk_gen (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst)
   );

   nandc_top u_nandc_top (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .wbs_adr_i (wbs_adr_i),
      .wbs_dat_i (wbs_dat_i),
      .wbs_sel_i (wbs_sel_i),
      .wbs_cyc_i (wbs_cyc_i),
      .wbs_stb_i (wbs_stb_i),
      .wbs_we_i  (wbs_we_i),
      .wbs_dat_o (wbs_dat_o),
      .wbs_ack_o (wbs_ack_o),
      .io_i      (io_from_flash),
      .io_o      (io_to_flash),
      .io_t      (io_t),
      .cle_o     (cle),
      .ale_o     (ale),
      .ce_n_o    (ce_n),
      .we_n_o    (we_n),
      .re_n_o    (re_n),
      .wp_n_o    (wp_n),
      .rb_n_i    (rb_n)
   );

   nand_flash_model #(
      .PAGE_BITS   (`NANDC_FPAGES),
      .BUSY_CYCLES (20)
   ) u_flash (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .cle_i  (cle),
      .ale_i  (ale),
      .ce_n_i (ce_n),
      .we_n_i (we_n),
      .re_n_i (re_n),
      .io_i   (io_to_flash),
      .io_o   (io_from_flash),
      .rb_n_o (rb_n)
   );

   always @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_cnt <= 0;
      end else begin
         cycle_cnt <= cycle_cnt + 1;
         if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: no end of test after %0d cycles", cycle_cnt);
            $display("Simulation failed");
            $fatal(1, "run stopped by timeout");
         end
      end
   end

   // count chip enable activations
   always @(posedge wb_clk) begin
      if (wb_rst) begin
         ce_falls <= 0;
         ce_n_q   <= 1'b1;
      end else begin
         ce_n_q <= ce_n;
         if (ce_n_q && !ce_n) begin
            ce_falls <= ce_falls + 1;
         end
      end
   end

   task automatic check_value(input string name, input host_word_t expected,
                              input host_word_t actual);
      if (actual !== expected) begin
         $display("Mismatch in %s: expected %08h, actual %08h", name, expected, actual);
         $display("Simulation failed");
         $fatal(1, "check of %s failed", name);
      end
   endtask

   function automatic host_word_t expect_read(input host_word_t off);
      host_word_t word;
      int         row;
      int         col;
      int         blk;
      row = int'(off >> `NANDC_FCOLUMNS) + (`NANDC_FLASH_S << `NANDC_FPAGES);
      col = int'(off) & ((1 << `NANDC_FCOLUMNS) - 1);
      blk = row >> `NANDC_FPAGES;
      // lowest column lands in the lowest byte
      for (int i = 0; i < 4; i++) begin
         if (ref_erased[blk]) begin
            word[8*i +: 8] = 8'hff;
         end else begin
            word[8*i +: 8] = 8'(row * 7 + col + i);
         end
      end
      return word;
   endfunction

   function automatic host_word_t status_bit();
      return ((ref_last_blk & 7) == 7) ? 32'd1 : 32'd0;
   endfunction

   // word aligned column in a random page of one block
   function automatic host_word_t random_offset(input int blk);
      host_word_t page;
      host_word_t col;
      page = $urandom_range((1 << `NANDC_FPAGES) - 1);
      col  = $urandom_range((1 << `NANDC_FCOLUMNS) - 1) & ~32'h3;
      return (host_word_t'(blk - `NANDC_FLASH_S) << WIN_BITS) |
             (page << `NANDC_FCOLUMNS) | col;
   endfunction

   task automatic bus_access(input logic we, input host_word_t adr, input host_word_t dat,
                             output host_word_t rdata);
      logic seen;
      wbs_adr_i = adr;
      wbs_dat_i = dat;
      wbs_we_i  = we;
      wbs_cyc_i = 1'b1;
      wbs_stb_i = 1'b1;
      seen      = 1'b0;
      while (!seen) begin
         @(posedge wb_clk);
         #1;
         seen = wbs_ack_o;
      end
      rdata = wbs_dat_o;
      // master ends the cycle one edge after ack
      @(posedge wb_clk);
      #1;
      wbs_cyc_i = 1'b0;
      wbs_stb_i = 1'b0;
      wbs_we_i  = 1'b0;
   endtask

   task automatic flash_read(input host_word_t off, input string name);
      host_word_t rdata;
      bus_access(1'b0, `NANDC_FLASH_BASE + off, '0, rdata);
      check_value(name, expect_read(off), rdata);
   endtask

   task automatic status_read(input string name);
      host_word_t rdata;
      bus_access(1'b0, STATUS_ADDR, '0, rdata);
      check_value(name, status_bit(), rdata);
   endtask

   task automatic block_erase(input int blk);
      host_word_t rdata;
      bus_access(1'b1, ERASE_ADDR, host_word_t'(blk), rdata);
      ref_erased[blk] = 1'b1;
      ref_last_blk    = blk;
      check_value("erase", status_bit(), rdata);
   endtask

   task automatic rejected_access(input logic we, input host_word_t adr,
                                  input host_word_t dat, input string name);
      host_word_t rdata;
      int         falls_before;
      falls_before = ce_falls;
      bus_access(we, adr, dat, rdata);
      repeat (3) @(posedge wb_clk);
      #1;
      check_value(name, 32'd0, rdata);
      check_value({name, " chip enable"}, host_word_t'(falls_before), host_word_t'(ce_falls));
   endtask

   initial begin
      int blk;
      int other;
      void'($urandom(60));
      wbs_adr_i    = '0;
      wbs_dat_i    = '0;
      wbs_sel_i    = 4'hf;
      wbs_cyc_i    = 1'b0;
      wbs_stb_i    = 1'b0;
      wbs_we_i     = 1'b0;
      ref_erased   = '0;
      ref_last_blk = 0;
      @(negedge wb_rst);
      @(posedge wb_clk);
      #1;

      // flash pins idle after reset
      check_value("reset ce_n", 32'd1, 32'(ce_n));
      check_value("reset we_n", 32'd1, 32'(we_n));
      check_value("reset re_n", 32'd1, 32'(re_n));
      check_value("reset wp_n", 32'd1, 32'(wp_n));
      check_value("reset cle", 32'd0, 32'(cle));
      check_value("reset ale", 32'd0, 32'(ale));
      check_value("reset io_t", 32'hff, 32'(io_t));

      status_read("status before erase");

      for (int i = 0; i < NUM_READS; i++) begin
         blk = `NANDC_FLASH_S + $urandom_range(`NANDC_FLASH_N - 1);
         flash_read(random_offset(blk), "random read");
      end

      for (int i = 0; i < NUM_ERASES; i++) begin
         // odd rounds hit block 7 or 15 whose numbers end in 111
         if (i % 2 == 1) begin
            blk = ($urandom_range(1) << 3) | 7;
         end else begin
            blk = `NANDC_FLASH_S + $urandom_range(`NANDC_FLASH_N - 1);
         end
         block_erase(blk);
         status_read("status after erase");
         flash_read(random_offset(blk), "read erased block");
         other = `NANDC_FLASH_S + ((blk - `NANDC_FLASH_S + 1 +
                 $urandom_range(`NANDC_FLASH_N - 2)) % `NANDC_FLASH_N);
         flash_read(random_offset(other), "read other block");
      end

      rejected_access(1'b0, WIN_END + ($urandom_range(32'hffff) & ~32'h3), '0,
                      "read past window");
      rejected_access(1'b0, STATUS_ADDR + 32'd4, '0, "read unmapped register");
      rejected_access(1'b1, `NANDC_FLASH_BASE + random_offset(`NANDC_FLASH_S),
                      32'h1234_5678, "write into window");
      rejected_access(1'b1, STATUS_ADDR, 32'd1, "write status register");
      rejected_access(1'b1, ERASE_ADDR, $urandom_range(`NANDC_FLASH_S - 1),
                      "erase below range");
      rejected_access(1'b1, ERASE_ADDR,
                      `NANDC_FLASH_S + `NANDC_FLASH_N + $urandom_range(255),
                      "erase above range");

      repeat (2) @(posedge wb_clk);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- nandc.f
+incdir+hw
hw/nand_flash_pkg.sv
hw/nand_host_pkg.sv
hw/nand_wb_slave.sv
hw/nand_op_seq.sv
hw/nand_cycle_gen.sv
hw/nandc_top.sv
test/tb_clk_gen.sv
test/nand_flash_model.sv
test/tb_nandc.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_nandc
FILELIST := nandc.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Simulation completed successfully

.PHONY: all compile run check clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the simulator status is ignored here, the log decides
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check:
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
